// ==== verification/fetch_trace.txt ====
# M word_address instruction | R records_accepted kind target_or_cycles | E expected_pc
# kinds: b branch, e ertn over a branch, x exception over ertn and branch, s stall cycles
M 1c000004 02800421
M 1c000008 02800842
M 1c000040 0280140c
M 1c000044 0015018d
M 1c000048 29800064
M 1c000080 028004a5
M 1c0000a0 06483800
M 1c0000c0 4c000020
M 1c000020 15000024
M 1c000024 03400000
R 2 b 1c000040
R 3 s 00000008
R 5 x 1c000080
R 6 e 1c0000a0
R 7 b 1c0000c2
R 8 x 1c000020
E 1c000004
E 1c000008
E 1c000040
E 1c000044
E 1c000048
E 1c000080
E 1c0000a0
E 1c0000c2
E 1c000020
E 1c000024

// ==== project.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/inst_sram.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
verification/fetch_assert.sv
verification/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/inst_sram.sv
      - verilog/fetch_stage.sv
      - verilog/fetch_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/fetch_assert.sv
      - verification/fetch_tb.sv

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int RESET_CYCLES = 10;

    logic       clk;
    logic       rst;
    redirect_t  redirect;
    logic       out_ready;
    logic       out_valid;
    fetch_out_t fetch_out;
    logic       discard;
    logic       sram_busy;
    logic       load_en;
    pc_t        load_addr;
    inst_t      load_data;

    pc_t    mem_addr[$];
    inst_t  mem_data[$];
    inst_t  image[pc_t];       // word-aligned copy of the memory image
    int     ev_after[$];       // accepted records before the event applies
    byte    ev_kind[$];
    pc_t    ev_target[$];
    pc_t    exp_pc[$];
    logic   trace_ready = 1'b0;
    integer seed = 32'he7ef_8333;

    fetch_top u_fetch_top (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .fetch_out (fetch_out),
        .discard   (discard),
        .sram_busy (sram_busy),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic read_trace();
        int    fd;
        int    n;
        int    after;
        byte   kind;
        pc_t   a;
        inst_t d;
        string line;
        fd = $fopen("verification/fetch_trace.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open verification/fetch_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                case (line.getc(0))
                    "M": begin
                        n = $sscanf(line, "M %h %h", a, d);
                        if (n != 2) begin
                            fail_run("malformed memory line in the trace");
                        end else begin
                            mem_addr.push_back(a);
                            mem_data.push_back(d);
                            image[{a[31:2], 2'b00}] = d;
                        end
                    end
                    "R": begin
                        n = $sscanf(line, "R %d %c %h", after, kind, a);
                        if (n != 3) begin
                            fail_run("malformed redirect line in the trace");
                        end else begin
                            ev_after.push_back(after);
                            ev_kind.push_back(kind);
                            ev_target.push_back(a);
                        end
                    end
                    "E": begin
                        n = $sscanf(line, "E %h", a);
                        if (n != 1) begin
                            fail_run("malformed expected record line in the trace");
                        end else begin
                            exp_pc.push_back(a);
                        end
                    end
                    default: ;  // comment or blank line
                endcase
            end
            $fclose(fd);
        end
    endtask

    // the losing redirect sources point somewhere else so a wrong priority shows up
    function automatic redirect_t make_redirect(input byte kind, input pc_t target);
        redirect_t r;
        r = '0;
        case (kind)
            "b": begin
                r.br_taken  = 1'b1;
                r.br_target = target;
            end
            "e": begin
                r.ertn_flush = 1'b1;
                r.ertn_entry = target;
                r.br_taken   = 1'b1;
                r.br_target  = target + 32'h100;
            end
            "x": begin
                r.ex_flush   = 1'b1;
                r.ex_entry   = target;
                r.ertn_flush = 1'b1;
                r.ertn_entry = target + 32'h200;
                r.br_taken   = 1'b1;
                r.br_target  = target + 32'h100;
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_pc(input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: fetch_out.pc is %h, expected %h", $time, got, exp);
            fail_run("record pc differs from the trace");
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: fetch_out.inst is %h, expected %h", $time, got, exp);
            fail_run("record instruction differs from the memory image");
        end
    endtask

    task automatic check_exception(input logic got_flag, input ecode_t got_ecode,
                                   input esubcode_t got_sub, input logic exp_flag,
                                   input ecode_t exp_ecode, input esubcode_t exp_sub);
        if (got_flag !== exp_flag || got_ecode !== exp_ecode || got_sub !== exp_sub) begin
            $display("mismatch at %0t: fetch_out exception is %b/%h/%h, expected %b/%h/%h",
                     $time, got_flag, got_ecode, got_sub, exp_flag, exp_ecode, exp_sub);
            fail_run("record exception tag is wrong");
        end
    endtask

    task automatic check_discard(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: discard is %b, expected %b", $time, got, exp);
            fail_run("discard does not match the flush and the pending record");
        end
    endtask

    task automatic check_record(input fetch_out_t rec, input pc_t pc);
        pc_t  word;
        logic adef;
        word = {pc[31:2], 2'b00};
        adef = pc[1:0] != 2'b00;  // a misaligned pc is tagged ADEF
        if (!image.exists(word)) begin
            fail_run("expected pc lies outside the memory image");
        end else begin
            check_pc(rec.pc, pc);
            check_inst(rec.inst, image[word]);
            check_exception(rec.has_exception, rec.ecode, rec.esubcode, adef,
                            adef ? `ECODE_ADEF : 6'h0, adef ? `ESUBCODE_ADEF : 9'h0);
        end
    endtask

    initial begin
        int   got;
        int   ev;
        int   stall_left;
        int   stall_age;
        logic taken;
        rst        = 1'b1;
        redirect   = '0;
        out_ready  = 1'b0;
        sram_busy  = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        got        = 0;
        ev         = 0;
        stall_left = 0;
        stall_age  = 0;
        read_trace();
        trace_ready = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            load_en <= i < mem_addr.size();
            if (i < mem_addr.size()) begin
                load_addr <= mem_addr[i];
                load_data <= mem_data[i];
            end
            @(posedge clk);
        end
        rst     <= 1'b0;
        load_en <= 1'b0;
        while (got < exp_pc.size()) begin
            redirect_t drive_redirect;
            logic      flush;
            drive_redirect = '0;
            if (ev < ev_after.size() && ev_after[ev] == got) begin
                if (ev_kind[ev] == "s") begin
                    stall_left = int'(ev_target[ev]);
                end else begin
                    drive_redirect = make_redirect(ev_kind[ev], ev_target[ev]);
                end
                ev++;
            end
            if (stall_left > 0) begin
                drive_redirect.br_stall    = 1'b1;  // decode waits on an unresolved branch
                drive_redirect.id_in_valid = 1'b1;
                // decode keeps draining so any fetch issued during the stall would surface
                out_ready <= 1'b1;
                sram_busy <= 1'b0;
                stall_left--;
                stall_age++;
            end else begin
                stall_age = 0;
                out_ready <= ($random(seed) & 3) != 0;
                sram_busy <= ($random(seed) & 3) == 0;
            end
            redirect <= drive_redirect;
            @(negedge clk);
            flush = redirect.ex_flush || redirect.ertn_flush;
            // with no record in the slot the flush may or may not meet a read in flight
            if (!flush || out_valid) begin
                check_discard(discard, flush);
            end
            // a record sitting next to a redirect is wrong-path and gets dropped
            taken = out_valid && out_ready && fetch_out.inst_valid && !discard &&
                    !(redirect.br_taken || redirect.ex_flush || redirect.ertn_flush);
            if (taken && stall_age > `INST_SRAM_LATENCY + 1) begin
                fail_run("a record with a new pc was accepted while the branch stall was held");
            end else if (taken) begin
                check_record(fetch_out, exp_pc[got]);
                got++;
            end
            @(posedge clk);
        end
        if (ev == ev_after.size()) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("stream ended before every redirect event was applied");
        end
    end

    initial begin
        wait (trace_ready);
        repeat (RESET_CYCLES + 64 * exp_pc.size()) @(posedge clk);
        fail_run("timeout while waiting for the expected records");
    end

endmodule

// ==== verification/fetch_assert.sv ====
`timescale 1ns/1ps

module fetch_assert import fetch_pkg::*; (
    input logic       clk,
    input logic       rst,
    input redirect_t  redirect,
    input logic       out_ready,
    input logic       out_valid,
    input fetch_out_t fetch_out,
    input logic       sram_busy,
    input sram_req_t  sram_req,
    input sram_resp_t sram_resp
);

    logic outstanding_q;  // a read was accepted and its data_ok is still owed
    logic redirect_now;

    assign redirect_now = redirect.ex_flush || redirect.ertn_flush || redirect.br_taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding_q <= 1'b0;
        end else if (sram_req.req && sram_resp.addr_ok) begin
            outstanding_q <= 1'b1;
        end else if (sram_resp.data_ok) begin
            outstanding_q <= 1'b0;
        end
    end

    data_ok_needs_read: assert property (@(posedge clk) disable iff (rst)
        sram_resp.data_ok |-> outstanding_q)
        else $error("data_ok without an outstanding read");

    busy_blocks_addr_ok: assert property (@(posedge clk) disable iff (rst)
        sram_busy |-> !sram_resp.addr_ok)
        else $error("addr_ok high while sram_busy is high");

    idle_after_reset: assert property (@(posedge clk)
        rst |=> !out_valid)
        else $error("out_valid high right after reset");

    record_holds: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !redirect_now |=>
            out_valid && fetch_out === $past(fetch_out))
        else $error("record changed while decode was not ready");

endmodule

bind fetch_top fetch_assert u_fetch_assert (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .fetch_out (fetch_out),
    .sram_busy (sram_busy),
    .sram_req  (sram_req),
    .sram_resp (sram_resp)
);

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  redirect_t  redirect,
    input  logic       out_ready,
    output logic       out_valid,
    output fetch_out_t fetch_out,
    output logic       discard,
    input  logic       sram_busy,
    input  logic       load_en,
    input  pc_t        load_addr,
    input  inst_t      load_data
);

    sram_req_t  sram_req;
    sram_resp_t sram_resp;

    fetch_stage u_fetch_stage (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .fetch_out (fetch_out),
        .discard   (discard),
        .sram_req  (sram_req),
        .sram_resp (sram_resp)
    );

    // busy only delays acceptance of the next read
    inst_sram u_inst_sram (
        .clk       (clk),
        .rst       (rst),
        .sram_req  (sram_req),
        .sram_resp (sram_resp),
        .sram_busy (sram_busy),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  redirect_t  redirect,
    input  logic       out_ready,
    output logic       out_valid,
    output fetch_out_t fetch_out,
    output logic       discard,
    output sram_req_t  sram_req,
    input  sram_resp_t sram_resp
);

    pc_t   pc_q;           // address of the most recently accepted fetch
    logic  inflight_q;
    logic  kill_q;
    logic  hold_valid_q;
    inst_t hold_inst_q;
    logic  redir_valid_q;
    pc_t   redir_pc_q;

    logic  flush;
    logic  redirect_now;
    logic  stall;
    logic  accept;
    logic  resp_good;
    logic  slot_free;
    logic  adef;
    pc_t   target_now;
    pc_t   seq_pc;
    pc_t   next_pc;

    assign flush        = redirect.ex_flush || redirect.ertn_flush;
    assign redirect_now = flush || redirect.br_taken;

    // exception entry beats exception return which beats a taken branch
    assign target_now = redirect.ex_flush   ? redirect.ex_entry   :
                        redirect.ertn_flush ? redirect.ertn_entry :
                        redirect.br_target;

    assign seq_pc = pc_q + 32'd4;

    // a redirect that could not issue right away is remembered in redir_pc_q
    assign next_pc = redirect_now  ? target_now :
                     redir_valid_q ? redir_pc_q :
                     seq_pc;

    assign stall = redirect.br_stall && redirect.id_in_valid && !flush;

    // one read in flight at a time, and nothing new while a word waits for decode
    assign sram_req.req  = !inflight_q && !hold_valid_q && !stall;
    assign sram_req.addr = {next_pc[31:2], 2'b00};

    assign accept    = sram_req.req && sram_resp.addr_ok;
    assign resp_good = sram_resp.data_ok && inflight_q && !kill_q && !redirect_now;
    assign slot_free = !out_valid || out_ready;
    assign adef      = pc_q[1:0] != 2'b00;

    // decode drops whatever it takes in this cycle and the wrong-path word never arrives
    assign discard = flush && (inflight_q || hold_valid_q || out_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= `FETCH_RESET_PC;
            redir_valid_q <= 1'b0;
        end else if (accept) begin
            pc_q          <= next_pc;
            redir_valid_q <= 1'b0;
        end else if (redirect_now) begin
            redir_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_now && !accept) begin
            redir_pc_q <= target_now;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_q <= 1'b0;
            kill_q     <= 1'b0;
        end else begin
            if (accept) begin
                inflight_q <= 1'b1;
            end else if (sram_resp.data_ok) begin
                inflight_q <= 1'b0;
            end
            if (sram_resp.data_ok) begin
                kill_q <= 1'b0;
            end else if (redirect_now && inflight_q) begin
                kill_q <= 1'b1;  // the read still owed by the memory is wrong-path
            end
        end
    end

    // the hold buffer catches a response while the record slot is still occupied
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid_q <= 1'b0;
        end else if (redirect_now) begin
            hold_valid_q <= 1'b0;
        end else if (hold_valid_q && slot_free) begin
            hold_valid_q <= 1'b0;
        end else if (resp_good && !slot_free) begin
            hold_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_good && !slot_free) begin
            hold_inst_q <= sram_resp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            fetch_out <= '0;
        end else if (redirect_now) begin
            out_valid               <= 1'b0;
            fetch_out.inst_valid    <= 1'b0;
            fetch_out.has_exception <= 1'b0;
        end else if (slot_free) begin
            if (hold_valid_q || resp_good) begin
                out_valid               <= 1'b1;
                fetch_out.pc            <= pc_q;
                fetch_out.inst          <= hold_valid_q ? hold_inst_q : sram_resp.rdata;
                fetch_out.inst_valid    <= 1'b1;
                fetch_out.has_exception <= adef;
                fetch_out.ecode         <= adef ? `ECODE_ADEF : 6'h0;
                fetch_out.esubcode      <= adef ? `ESUBCODE_ADEF : 9'h0;
            end else begin
                out_valid            <= 1'b0;
                fetch_out.inst_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/inst_sram.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_sram import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  sram_req_t  sram_req,
    output sram_resp_t sram_resp,
    input  logic       sram_busy,
    input  logic       load_en,
    input  pc_t        load_addr,
    input  inst_t      load_data
);

    localparam int IDX_W = $clog2(`INST_SRAM_WORDS);
    localparam int CNT_W = $clog2(`INST_SRAM_LATENCY + 1);

    inst_t            mem [`INST_SRAM_WORDS];
    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] rd_idx_q;
    logic [CNT_W-1:0] count_q;  // cycles left before the response goes out
    logic             pending_q;
    logic             data_ok_q;
    inst_t            rdata_q;
    logic             addr_ok;
    logic             accept;
    logic             fire;

    assign addr_ok = !pending_q && !sram_busy;
    assign accept  = sram_req.req && addr_ok;
    assign req_idx = sram_req.addr[IDX_W+1:2];

    // fire is the cycle before data_ok so the response leaves a register
    assign fire = (`INST_SRAM_LATENCY == 1) ? accept : (pending_q && count_q == CNT_W'(1));

    assign sram_resp.addr_ok = addr_ok;
    assign sram_resp.data_ok = data_ok_q;
    assign sram_resp.rdata   = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
            count_q   <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= fire;
            if (accept) begin
                pending_q <= `INST_SRAM_LATENCY > 1;
                count_q   <= CNT_W'(`INST_SRAM_LATENCY - 1);
            end else if (fire) begin
                pending_q <= 1'b0;
            end else if (pending_q) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[IDX_W+1:2]] <= load_data;  // only used while fetch sits in reset
        end
        if (accept) begin
            rd_idx_q <= req_idx;
        end
        if (fire) begin
            rdata_q <= mem[(`INST_SRAM_LATENCY == 1) ? req_idx : rd_idx_q];
        end
    end

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0] pc_t;       // byte address
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // everything the later stages send back to fetch
    typedef struct packed {
        logic ex_flush;
        pc_t  ex_entry;
        logic ertn_flush;
        pc_t  ertn_entry;
        logic br_taken;
        pc_t  br_target;
        logic br_stall;    // branch unresolved in decode
        logic id_in_valid;
    } redirect_t;

    // read-only word requests on the sram-like bus
    typedef struct packed {
        logic req;
        pc_t  addr;
    } sram_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        inst_t rdata;      // only meaningful while data_ok is high
    } sram_resp_t;

    // record handed to decode
    typedef struct packed {
        pc_t       pc;
        inst_t     inst;
        logic      inst_valid;
        logic      has_exception;
        ecode_t    ecode;
        esubcode_t esubcode;
    } fetch_out_t;

endpackage

// ==== verilog/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// the first sequential fetch goes to this address plus 4
`define FETCH_RESET_PC 32'h1c000000

// instruction memory geometry in 32-bit words
`define INST_SRAM_WORDS 256

// cycles from address acceptance to data_ok when the memory is idle
`define INST_SRAM_LATENCY 2

// instruction fetch address error
`define ECODE_ADEF 6'h8
`define ESUBCODE_ADEF 9'h0

`endif
